// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := glueLogicTb
FILELIST  := compile.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TB PASSED$$"

clean:
	rm -rf $(OBJDIR)

// ==== compile.f ====
verilog/glueBusPkg.sv
verilog/busSelectIf.sv
verilog/busCycleTracker.sv
verilog/chipSelectDecoder.sv
verilog/classWaitTimer.sv
verilog/ackMerger.sv
verilog/glueLogicTop.sv
verification/glueLogic_asserts.sv
verification/glueLogicTb.sv

// ==== verification/glueLogicTb.sv ====
`timescale 1ns/1ps

module glueLogicTb
	import glueBusPkg::*;
();

	localparam int RESET_CYCLES = 16;
	localparam int NUM_TRANS    = 68;  // bus cycles issued below
	localparam int CYCLE_LIMIT  = NUM_TRANS * 300 + RESET_CYCLES;
	localparam int ACK_LIMIT    = 16;  // longest legal wait is far below this
	localparam int SEED         = 32'h155e2114;

	// expected response of one bus cycle
	typedef struct {
		logic [8:0] sel;     // select outputs in selNames order
		int         cls;     // class index
		logic       useVpa;  // autovector answered on nVPA
		int         waitCnt; // wait states of the class
	} expectT;

	logic        CLK;
	logic        reset;
	logic [23:8] A;
	logic        nAS;
	logic        nWE;
	logic        Overlay;
	logic        IOCS;
	logic        IOPWCS;
	logic        IACS;
	logic        ROMCS;
	logic        ROMCS4X;
	logic        RAMCS;
	logic        RAMCS0X;
	logic        SndRAMCSWR;
	logic        nDTACK;
	logic        nVPA;

	int          errorCount = 0;
	int          checkCount = 0;
	int          cycleCount = 0;
	logic        overlayRef;      // model copy of the overlay latch
	logic        checkArm = 1'b0; // select compare enabled
	logic [8:0]  expSel;
	logic [8:0]  selActual;
	string       selNames [9] = '{"Overlay", "IOCS", "IOPWCS", "IACS", "ROMCS",
		"ROMCS4X", "RAMCS", "RAMCS0X", "SndRAMCSWR"};

	assign selActual = {SndRAMCSWR, RAMCS0X, RAMCS, ROMCS4X, ROMCS, IACS, IOPWCS,
		IOCS, Overlay};

	glueLogicTop u_dut (
		.CLK        (CLK),
		.reset      (reset),
		.A          (A),
		.nAS        (nAS),
		.nWE        (nWE),
		.Overlay    (Overlay),
		.IOCS       (IOCS),
		.IOPWCS     (IOPWCS),
		.IACS       (IACS),
		.ROMCS      (ROMCS),
		.ROMCS4X    (ROMCS4X),
		.RAMCS      (RAMCS),
		.RAMCS0X    (RAMCS0X),
		.SndRAMCSWR (SndRAMCSWR),
		.nDTACK     (nDTACK),
		.nVPA       (nVPA)
	);

	bind ackMerger glueLogic_asserts u_asserts (
		.CLK         (CLK),
		.reset       (reset),
		.cycleActive (bus.cycleActive),
		.ready       (ready),
		.nDTACK      (nDTACK),
		.nVPA        (nVPA)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK; // 4 ns period
	end

	// run limit
	always @(posedge CLK) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TB FAILED");
			$finish;
		end
	end

	// decode rules of the glue block from address, write level and overlay
	function automatic expectT expectSelects(input logic [23:8] addr, input logic wr,
		input logic ovl);
		expectT     r;
		logic [3:0] top;
		logic       pageWr;
		logic       sndHit;
		top    = addr[23:20];
		pageWr = (addr[23:16] == 8'h3F) && wr; // video and sound write page
		sndHit = ((addr[15:12] == 4'hA) && (addr[11:8] >= 4'h1) && (addr[11:8] <= 4'h3)) ||
			((addr[15:12] == 4'hF) && (addr[11:8] >= 4'hD));
		r.sel[0] = ovl;
		r.sel[1] = (top >= 4'h5) || ((top == 4'h4) && ovl) || pageWr; // IOCS
		r.sel[2] = pageWr;
		r.sel[3] = addr[23:16] == 8'hFF; // interrupt acknowledge space
		r.sel[5] = top == 4'h4;
		r.sel[4] = ovl || r.sel[5];
		r.sel[7] = addr[23:22] == 2'b00;
		r.sel[6] = r.sel[7] && !ovl;
		r.sel[8] = pageWr && sndHit;
		if (r.sel[3]) begin
			r.cls = CLASS_IACK;
		end else if (r.sel[1]) begin
			r.cls = CLASS_IO;
		end else if (r.sel[4]) begin
			r.cls = CLASS_ROM;
		end else begin
			r.cls = CLASS_RAM;
		end
		r.useVpa  = r.cls == CLASS_IACK;
		r.waitCnt = int'(WAIT_STATES[r.cls]);
		return r;
	endfunction

	task automatic reportMismatch(input string name, input int expV, input int gotV);
		$display("CHECK FAILED t=%0t %s expected %0h got %0h", $time, name, expV, gotV);
		errorCount++;
	endtask

	// acknowledge pins against the expected level
	task automatic checkAckPins(input logic useVpa, input logic ackLow);
		logic expDtack;
		logic expVpa;
		expDtack = !(ackLow && !useVpa);
		expVpa   = !(ackLow && useVpa);
		checkCount++;
		if (nDTACK !== expDtack) begin
			reportMismatch("nDTACK", int'(expDtack), int'(nDTACK));
		end
		if (nVPA !== expVpa) begin
			reportMismatch("nVPA", int'(expVpa), int'(nVPA));
		end
	endtask

	// one CPU cycle entered and left 1 ns after a rising edge
	task automatic busCycle(input logic [23:8] addr, input logic wr, input int extraHold);
		expectT startExp;
		expectT endExp;
		int     edges;
		startExp = expectSelects(addr, wr, overlayRef); // class fixed at cycle start
		if (addr[23:20] == 4'h4) begin
			overlayRef = 1'b0; // 4x window access drops the overlay
		end
		endExp = expectSelects(addr, wr, overlayRef);
		expSel = endExp.sel;
		A      = addr;
		nWE    = !wr;
		nAS    = 1'b0;
		@(posedge CLK); // edge sampling nAS low
		#1;
		edges = 0;
		while (nDTACK && nVPA && edges < ACK_LIMIT) begin
			@(posedge CLK);
			#1;
			edges++;
			if (edges == 2) begin
				checkArm = 1'b1; // overlay settled from here
			end
		end
		if (nDTACK && nVPA) begin
			$display("no acknowledge for address %h within %0d cycles", addr, ACK_LIMIT);
			errorCount++;
		end else begin
			checkCount++;
			if (edges != startExp.waitCnt + 2) begin
				reportMismatch("ack delay", startExp.waitCnt + 2, edges);
			end
			checkAckPins(startExp.useVpa, 1'b1);
			repeat (2 + extraHold) begin
				@(posedge CLK);
				#1;
				checkAckPins(startExp.useVpa, 1'b1); // held while nAS low
			end
		end
		checkArm = 1'b0;
		nAS      = 1'b1;
		nWE      = 1'b1;
		@(posedge CLK); // edge sampling nAS high
		#1;
		checkAckPins(startExp.useVpa, 1'b1);
		@(posedge CLK);
		#1;
		checkAckPins(startExp.useVpa, 1'b0); // released
		@(posedge CLK);
		#1;
		checkAckPins(startExp.useVpa, 1'b0); // no second ack
	endtask

	// select compare mid-cycle where outputs are stable
	always @(negedge CLK) begin
		if (checkArm) begin
			checkCount++;
			for (int i = 0; i < 9; i++) begin
				if (selActual[i] !== expSel[i]) begin
					reportMismatch(selNames[i], int'(expSel[i]), int'(selActual[i]));
				end
			end
		end
	end

	initial begin
		logic [31:0] rnd;
		logic [7:0]  subPages [10];
		rnd        = $urandom(SEED);
		subPages   = '{8'hA0, 8'hA1, 8'hA2, 8'hA3, 8'hA4, 8'hFC, 8'hFD, 8'hFE, 8'hFF, 8'hB2};
		reset      = 1'b1;
		A          = '0;
		nAS        = 1'b1;
		nWE        = 1'b1;
		overlayRef = 1'b1;
		expSel     = '0;
		repeat (RESET_CYCLES) @(posedge CLK);
		#1;
		reset = 1'b0;
		checkCount++;
		if (Overlay !== 1'b1) begin
			reportMismatch("Overlay", 1, int'(Overlay));
		end
		checkAckPins(1'b0, 1'b0); // both pins idle high after reset
		// boot overlay until the 4x window turns it off
		busCycle(16'h0000, 1'b0, 0);
		busCycle(16'h4000, 1'b0, 0);
		busCycle(16'h0000, 1'b0, 0);
		busCycle(16'h0010, 1'b1, 0);
		// every top nibble then anything
		for (int i = 0; i < 16; i++) begin
			rnd = $urandom;
			busCycle({i[3:0], rnd[11:0]}, rnd[12], 0);
		end
		for (int i = 0; i < 16; i++) begin
			rnd = $urandom;
			busCycle(rnd[15:0], rnd[16], 0);
		end
		// write page and its sound sub-pages
		foreach (subPages[i]) begin
			busCycle({8'h3F, subPages[i]}, 1'b1, 0);
			busCycle({8'h3F, subPages[i]}, 1'b0, 0);
		end
		// one per class
		busCycle(16'h4123, 1'b0, 0);
		busCycle(16'h0100, 1'b1, 0);
		busCycle(16'h8000, 1'b0, 0);
		busCycle(16'hFFF0, 1'b0, 0);
		// interrupt acknowledge
		repeat (6) begin
			rnd = $urandom;
			busCycle({8'hFF, rnd[7:0]}, rnd[8], 0);
		end
		// long held strobe
		busCycle(16'h0234, 1'b0, 40);
		busCycle(16'hFF07, 1'b0, 40);
		repeat (2) @(posedge CLK);
		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== verification/glueLogic_asserts.sv ====
`timescale 1ns/1ps

module glueLogic_asserts
	import glueBusPkg::*;
(
	input logic     CLK,
	input logic     reset,
	input logic     cycleActive,
	input classVecT ready,
	input logic     nDTACK,
	input logic     nVPA
);

	// DTACK and VPA never answer the same cycle
	a_ackExclusive: assert property (@(posedge CLK) disable iff (reset)
		!(!nDTACK && !nVPA))
		else $error("nDTACK and nVPA low together");

	// acknowledge only while a class timer still reports ready
	a_ackWithReady: assert property (@(posedge CLK) disable iff (reset)
		(!nDTACK || !nVPA) |-> (ready != '0))
		else $error("acknowledge low without a ready class");

	// ready bits follow the one-hot class select
	a_readyOneHot: assert property (@(posedge CLK) disable iff (reset)
		$onehot0(ready))
		else $error("more than one class ready");

	// acknowledge held until the strobe is released
	a_ackHeld: assert property (@(posedge CLK) disable iff (reset)
		(cycleActive && (!nDTACK || !nVPA)) |=> ($stable(nDTACK) && $stable(nVPA)))
		else $error("acknowledge dropped inside a bus cycle");

endmodule

// ==== verilog/ackMerger.sv ====
`timescale 1ns/1ps

module ackMerger
	import glueBusPkg::*;
(
	input  logic       CLK,
	input  logic       reset,
	busSelectIf.merger bus,
	input  classVecT   ready,
	output logic       nDTACK,
	output logic       nVPA
);

	logic dataReady; // any memory or IO class done
	logic iackReady;

	assign dataReady = ready[CLASS_ROM] || ready[CLASS_RAM] || ready[CLASS_IO];
	assign iackReady = ready[CLASS_IACK]; // answered with VPA, autovector

	always_ff @(posedge CLK) begin
		if (reset) begin
			nDTACK <= 1'b1;
			nVPA   <= 1'b1;
		end else begin
			nDTACK <= !(bus.cycleActive && dataReady); // high once cycle ends
			nVPA   <= !(bus.cycleActive && iackReady);
		end
	end

endmodule

// ==== verilog/busCycleTracker.sv ====
`timescale 1ns/1ps

module busCycleTracker (
	input  logic        CLK,
	input  logic        reset,
	input  logic [23:8] A,
	input  logic        nAS,
	input  logic        nWE,
	busSelectIf.tracker bus
);

	logic asPrev; // strobe level seen on the previous edge
	logic startNow;

	// falling strobe, first low sample after a high one
	assign startNow = !nAS && asPrev;

	always_ff @(posedge CLK) begin
		if (reset) begin
			asPrev          <= 1'b1; // strobe idles high
			bus.cycleStart  <= 1'b0;
			bus.cycleActive <= 1'b0;
		end else begin
			asPrev         <= nAS;
			bus.cycleStart <= startNow; // single pulse per cycle
			if (nAS) begin
				bus.cycleActive <= 1'b0; // strobe released, cycle over
			end else if (bus.cycleStart) begin
				bus.cycleActive <= 1'b1; // edge after the start edge
			end
		end
	end

	// address and direction held for the whole cycle
	always_ff @(posedge CLK) begin
		if (startNow) begin
			bus.addr  <= A;
			bus.write <= !nWE; // nWE low means write
		end
	end

endmodule

// ==== verilog/busSelectIf.sv ====
`timescale 1ns/1ps

interface busSelectIf
	import glueBusPkg::*;
();

	logic [23:8] addr;        // latched upper address
	logic        write;       // latched write level, high on write
	logic        cycleActive; // bus cycle in progress
	logic        cycleStart;  // one clock, first cycle after strobe
	classVecT    classSel;    // one-hot device class

	modport tracker (
		output addr, write, cycleActive, cycleStart
	);

	modport decoder (
		input  addr, write, cycleActive, cycleStart,
		output classSel
	);

	modport timer (
		input cycleActive, cycleStart
	);

	modport merger (
		input cycleActive
	);

endinterface

// ==== verilog/chipSelectDecoder.sv ====
`timescale 1ns/1ps

module chipSelectDecoder
	import glueBusPkg::*;
(
	input  logic        CLK,
	input  logic        reset,
	busSelectIf.decoder bus,
	output logic        Overlay,
	output logic        IOCS,
	output logic        IOPWCS,
	output logic        IACS,
	output logic        ROMCS,
	output logic        ROMCS4X,
	output logic        RAMCS,
	output logic        RAMCS0X,
	output logic        SndRAMCSWR
);

	logic [3:0] topNibble; // A23:20
	logic [3:0] subBank;   // A15:12
	logic [3:0] subPage;   // A11:8
	logic       vidPageWr; // write anywhere in 3Fxxxx
	logic       sndLoHit;
	logic       sndHiHit;
	logic       inCycle;
	logic       overlayOn;

	assign topNibble = bus.addr[23:20];
	assign subBank   = bus.addr[15:12];
	assign subPage   = bus.addr[11:8];

	// overlay latch, cleared by the first real ROM window access
	always_ff @(posedge CLK) begin
		if (reset) begin
			overlayOn <= OVERLAY_AT_RESET;
		end else if (bus.cycleActive && ROMCS4X) begin
			overlayOn <= 1'b0; // stays off until next reset
		end
	end

	assign Overlay = overlayOn;

	// ROM
	assign ROMCS4X = topNibble == ROM_REGION;
	assign ROMCS   = overlayOn || ROMCS4X; // overlay mirrors ROM at 000000

	// RAM, hidden under overlay
	assign RAMCS0X = bus.addr[23:22] == RAM_REGION;
	assign RAMCS   = RAMCS0X && !overlayOn;

	// video and sound write page
	assign vidPageWr = (bus.addr[23:16] == VID_PAGE) && bus.write;
	assign IOPWCS    = vidPageWr;

	assign sndLoHit = (subBank == SND_LO_BANK) &&
		(subPage >= SND_LO_FIRST) && (subPage <= SND_LO_LAST); // A1..A3
	assign sndHiHit = (subBank == SND_HI_BANK) &&
		(subPage >= SND_HI_FIRST) && (subPage <= SND_HI_LAST); // FD..FF
	assign SndRAMCSWR = vidPageWr && (sndLoHit || sndHiHit);

	// interrupt acknowledge space
	assign IACS = bus.addr[23:16] == IACK_PAGE;

	// IO space, 5x..Fx plus ROM slot under overlay plus write page
	assign IOCS = (topNibble >= IO_FIRST) ||
		((topNibble == ROM_REGION) && overlayOn) ||
		vidPageWr;

	// class select valid from the start pulse to end of cycle
	assign inCycle = bus.cycleActive || bus.cycleStart;

	always_comb begin
		bus.classSel = '0;
		if (inCycle) begin
			if (IACS) begin
				bus.classSel[CLASS_IACK] = 1'b1; // autovector
			end else if (IOCS) begin
				bus.classSel[CLASS_IO] = 1'b1;
			end else if (ROMCS) begin
				bus.classSel[CLASS_ROM] = 1'b1;
			end else begin
				bus.classSel[CLASS_RAM] = 1'b1; // everything else is RAM
			end
		end
	end

endmodule

// ==== verilog/classWaitTimer.sv ====
`timescale 1ns/1ps

module classWaitTimer
	import glueBusPkg::*;
#(
	parameter logic [WAIT_W-1:0] WAIT = '0 // wait states for this class
) (
	input  logic      CLK,
	input  logic      reset,
	busSelectIf.timer bus,
	input  logic      classSel,
	output logic      ready
);

	logic [WAIT_W-1:0] count; // remaining wait states
	logic              cycleIdle;

	// between cycles, start pulse not yet seen
	assign cycleIdle = !bus.cycleActive && !bus.cycleStart;

	always_ff @(posedge CLK) begin
		if (reset) begin
			count <= '0;
			ready <= 1'b0;
		end else if (bus.cycleStart && classSel) begin
			count <= WAIT;              // arm for this cycle
			ready <= (WAIT == '0);      // zero-wait class is ready at once
		end else if (cycleIdle) begin
			count <= '0;
			ready <= 1'b0;              // drop with the cycle
		end else if (count != '0) begin
			count <= count - 1'b1;
			if (count == 1'b1) begin
				ready <= 1'b1;          // last wait state done
			end
		end
	end

	// ready holds while count sits at zero, no re-arm inside a cycle

endmodule

// ==== verilog/glueBusPkg.sv ====
package glueBusPkg;

	// device classes, one bit each in the class vector
	localparam int NUM_CLASSES = 4;

	localparam int CLASS_ROM  = 0; // boot ROM, 4x window or overlay
	localparam int CLASS_RAM  = 1; // main RAM, default target
	localparam int CLASS_IO   = 2; // peripherals and video write page
	localparam int CLASS_IACK = 3; // interrupt acknowledge, autovectored

	typedef logic [NUM_CLASSES-1:0] classVecT; // one-hot class select

	// wait-state counter width
	localparam int WAIT_W = 3;

	// wait counts per class, indexed by class number
	localparam logic [NUM_CLASSES-1:0][WAIT_W-1:0] WAIT_STATES = {
		3'd3, // IACK
		3'd4, // IO
		3'd0, // RAM
		3'd2  // ROM
	};

	// region codes on the upper address lines
	localparam logic [3:0] ROM_REGION = 4'h4;   // top nibble of ROM window
	localparam logic [1:0] RAM_REGION = 2'b00;  // A23:22 of low RAM
	localparam logic [7:0] VID_PAGE   = 8'h3F;  // video and sound write page
	localparam logic [7:0] IACK_PAGE  = 8'hFF;  // CPU drives FFxxxx during IACK
	localparam logic [3:0] IO_FIRST   = 4'h5;   // lowest nibble of the IO space

	// sound buffer sub-pages within the write page
	localparam logic [3:0] SND_LO_BANK  = 4'hA; // A1..A3
	localparam logic [3:0] SND_LO_FIRST = 4'h1;
	localparam logic [3:0] SND_LO_LAST  = 4'h3;
	localparam logic [3:0] SND_HI_BANK  = 4'hF; // FD..FF
	localparam logic [3:0] SND_HI_FIRST = 4'hD;
	localparam logic [3:0] SND_HI_LAST  = 4'hF;

	// overlay maps ROM at zero from reset
	localparam logic OVERLAY_AT_RESET = 1'b1;

endpackage

// ==== verilog/glueLogicTop.sv ====
`timescale 1ns/1ps

module glueLogicTop
	import glueBusPkg::*;
(
	input  logic        CLK,
	input  logic        reset,
	input  logic [23:8] A,
	input  logic        nAS,
	input  logic        nWE,
	output logic        Overlay,
	output logic        IOCS,
	output logic        IOPWCS,
	output logic        IACS,
	output logic        ROMCS,
	output logic        ROMCS4X,
	output logic        RAMCS,
	output logic        RAMCS0X,
	output logic        SndRAMCSWR,
	output logic        nDTACK,
	output logic        nVPA
);

	busSelectIf selBus ();

	classVecT readyVec; // per-class ready levels

	busCycleTracker u_tracker (
		.CLK   (CLK),
		.reset (reset),
		.A     (A),
		.nAS   (nAS),
		.nWE   (nWE),
		.bus   (selBus.tracker)
	);

	chipSelectDecoder u_decoder (
		.CLK        (CLK),
		.reset      (reset),
		.bus        (selBus.decoder),
		.Overlay    (Overlay),
		.IOCS       (IOCS),
		.IOPWCS     (IOPWCS),
		.IACS       (IACS),
		.ROMCS      (ROMCS),
		.ROMCS4X    (ROMCS4X),
		.RAMCS      (RAMCS),
		.RAMCS0X    (RAMCS0X),
		.SndRAMCSWR (SndRAMCSWR)
	);

	// one wait timer per class, wait count from the table
	for (genvar i = 0; i < NUM_CLASSES; i++) begin : g_timer
		classWaitTimer #(
			.WAIT (WAIT_STATES[i])
		) u_timer (
			.CLK      (CLK),
			.reset    (reset),
			.bus      (selBus.timer),
			.classSel (selBus.classSel[i]),
			.ready    (readyVec[i])
		);
	end

	ackMerger u_merger (
		.CLK    (CLK),
		.reset  (reset),
		.bus    (selBus.merger),
		.ready  (readyVec),
		.nDTACK (nDTACK),
		.nVPA   (nVPA)
	);

endmodule
